/* logic/neoPkg.sv */
package neoPkg;

	// CPU address map, byte addresses on 24 bits

	// Palette RAM window 0x400000 to 0x7FFFFF
	// Only A23 and A22 take part in the decode
	localparam logic [23:0] palBase = 24'h400000;
	localparam logic [23:0] palMask = 24'hC00000;

	// System latch window 0x3A0000 to 0x3BFFFF
	// Decoded on A23 down to A17
	localparam logic [23:0] latchBase = 24'h3A0000;
	localparam logic [23:0] latchMask = 24'hFE0000;

	// Latch bit numbers, taken from A3..A1
	localparam logic [2:0] latchShadow  = 3'd0;
	localparam logic [2:0] latchPalBank = 3'd7;

	// Value seen by the CPU on reads nobody answers
	localparam logic [15:0] openBusWord = 16'hFFFF;

	// Palette word seen as colour fields
	// MSB first: dark, three channel LSBs, then R, G, B nibbles
	typedef struct packed {
		logic       darkBit;
		logic       rLsb;
		logic       gLsb;
		logic       bLsb;
		logic [3:0] r4;
		logic [3:0] g4;
		logic [3:0] b4;
	} palCol;

	// Same 16 bits, bus view or colour view
	// CPU side moves raw words, video side reads col
	typedef union packed {
		logic [15:0] raw;
		palCol       col;
	} palWord;

	// Width check, the two views must overlay exactly
	// 1 + 3 + 12 bits gives the 16-bit bus word
	// Anything else would break the union

endpackage

/* logic/busDecode.sv */
module busDecode import neoPkg::*; #(
	parameter int palWaitStates = 1
) (
	input  logic        clk24M,
	input  logic        rstN,
	input  logic [23:1] cpuAddr,
	input  logic        nAs,
	input  logic        nUds,
	input  logic        nLds,
	input  logic        cpuRw,
	output logic        palCs,
	output logic [1:0]  palWe,
	output logic        latchWe,
	output logic        cpuRdSel,
	output logic        nDtack
);

	// Wait counter sized for the palette wait count
	localparam int cntW = (palWaitStates > 0) ? $clog2(palWaitStates + 1) : 1;

	logic [23:0]     byteAddr;
	logic            hitPal;
	logic            hitLatch;
	logic            busy;
	logic            regPal;
	logic            regLatch;
	logic            isRead;
	logic [cntW-1:0] waitCnt;
	logic            commit;

	// 68K has no A0, strobes stand in for it
	assign byteAddr = {cpuAddr, 1'b0};

	// Region compare against the package map
	assign hitPal   = (byteAddr & palMask) == palBase;
	assign hitLatch = (byteAddr & latchMask) == latchBase;

	// Last cycle of the wait, nDtack falls on the next edge
	// Writes land on that same edge
	assign commit = busy & nDtack & ~nAs & (waitCnt == '0);

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			busy     <= 1'b0;
			regPal   <= 1'b0;
			regLatch <= 1'b0;
			isRead   <= 1'b1;
			waitCnt  <= '0;
			nDtack   <= 1'b1;
		end else if (busy && nAs) begin
			// Master let go of nAs, end of cycle
			busy    <= 1'b0;
			nDtack  <= 1'b1;
			waitCnt <= '0;
		end else if (!busy && !nAs) begin
			// Start edge, region frozen for the whole cycle
			busy     <= 1'b1;
			regPal   <= hitPal;
			regLatch <= hitLatch;
			isRead   <= cpuRw;
			waitCnt  <= hitPal ? cntW'(palWaitStates) : '0;
		end else if (commit) begin
			nDtack <= 1'b0;
		end else if (busy && nDtack) begin
			waitCnt <= waitCnt - 1'b1;
		end
	end

	// Palette chip select, held while the cycle runs
	assign palCs = busy & regPal;

	// Read data from palette, otherwise open bus
	assign cpuRdSel = palCs & isRead;

	// Byte lanes: UDS is D15..D8, LDS is D7..D0
	assign palWe = (commit & regPal & ~isRead) ? {~nUds, ~nLds} : 2'b00;

	// Latch ignores the strobes, any write flips one bit
	assign latchWe = commit & regLatch & ~isRead;

endmodule

/* logic/sysLatch.sv */
module sysLatch import neoPkg::*; (
	input  logic       clk24M,
	input  logic       rstN,
	input  logic       latchWe,
	input  logic [2:0] bitSel,
	input  logic       bitVal,
	output logic       shadow,
	output logic       palBank
);

	// Board latch, one addressable flop per bit
	// Bit map as on the board:
	//   0  shadow
	//   1  vector table swap
	//   2  card write enable
	//   3  card write enable, second
	//   4  card register select
	//   5  BIOS / cart fix select
	//   6  backup RAM write enable
	//   7  palette bank
	logic [7:0] latchBits;

	// A4 carries the value, A3..A1 pick the bit
	// Other bits keep their state
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			latchBits <= 8'h00;
		end else if (latchWe) begin
			latchBits[bitSel] <= bitVal;
		end
	end

	// Only the two video bits leave this slice
	assign shadow  = latchBits[latchShadow];
	assign palBank = latchBits[latchPalBank];

	// Bits 1 to 6 stay in storage
	// Their users sit outside this top level

endmodule

/* logic/paletteRam.sv */
module paletteRam import neoPkg::*; #(
	parameter int palAddrW = 12
) (
	input  logic                clk24M,
	input  logic                rstN,
	input  logic                palBank,
	input  logic [palAddrW-1:0] cpuIdx,
	input  logic [1:0]          palWe,
	input  logic [15:0]         cpuWrData,
	output palWord              cpuPalData,
	input  logic [palAddrW-1:0] pixIdx,
	input  logic                blank,
	output palWord              vidWord,
	output logic                vidBlank
);

	// Two banks of 2^palAddrW words
	localparam int depth = 2 ** (palAddrW + 1);

	logic [15:0]       mem [depth];
	logic [depth-1:0]  valid;
	logic [palAddrW:0] cpuSlot;
	logic [palAddrW:0] vidSlot;
	logic [15:0]       cpuOld;
	logic [15:0]       cpuNew;
	logic              cpuWrite;

	// Bank bit on top of the index, both ports
	assign cpuSlot = {palBank, cpuIdx};
	assign vidSlot = {palBank, pixIdx};

	// Unwritten words read as zero
	assign cpuOld = valid[cpuSlot] ? mem[cpuSlot] : 16'h0000;

	// CPU read is combinational at the held address
	assign cpuPalData.raw = cpuOld;

	assign cpuWrite = |palWe;

	// Merge the enabled byte lanes into the current word
	always_comb begin
		cpuNew = cpuOld;
		if (palWe[1]) begin
			cpuNew[15:8] = cpuWrData[15:8];
		end
		if (palWe[0]) begin
			cpuNew[7:0] = cpuWrData[7:0];
		end
	end

	// Storage array
	always_ff @(posedge clk24M) begin
		if (cpuWrite) begin
			mem[cpuSlot] <= cpuNew;
		end
	end

	// Written-word map, cleared on reset
	// So both banks look blank after reset
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			valid <= '0;
		end else if (cpuWrite) begin
			valid[cpuSlot] <= 1'b1;
		end
	end

	// Video lookup, one cycle
	// Blank travels along with the word
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			vidWord.raw <= 16'h0000;
			vidBlank    <= 1'b1;
		end else begin
			vidWord.raw <= valid[vidSlot] ? mem[vidSlot] : 16'h0000;
			vidBlank    <= blank;
		end
	end

	// Separate ports, a CPU write never holds off a pixel
	// Same-cycle hit on one word gives the old value to video

endmodule

/* logic/videoOut.sv */
module videoOut import neoPkg::*; (
	input  logic       clk24M,
	input  logic       rstN,
	input  palWord     vidWord,
	input  logic       vidBlank,
	input  logic       shadow,
	output logic [6:0] videoR,
	output logic [6:0] videoG,
	output logic [6:0] videoB
);

	// Second pipe stage after the palette lookup

	logic [5:0] chanR;
	logic [5:0] chanG;
	logic [5:0] chanB;

	// Nibble, channel LSB, then inverted dark bit
	// Dark set means one step dimmer
	function automatic logic [5:0] buildChan(
		input logic [3:0] field,
		input logic       lsb,
		input logic       darkBit
	);
		return {field, lsb, ~darkBit};
	endfunction

	// Normal level sits at the top of the 7 bits
	// Shadow shifts it down one, half brightness
	function automatic logic [6:0] placeChan(
		input logic [5:0] chan,
		input logic       shade
	);
		return shade ? {1'b0, chan} : {chan, 1'b0};
	endfunction

	// Colour view of the word
	assign chanR = buildChan(vidWord.col.r4, vidWord.col.rLsb, vidWord.col.darkBit);
	assign chanG = buildChan(vidWord.col.g4, vidWord.col.gLsb, vidWord.col.darkBit);
	assign chanB = buildChan(vidWord.col.b4, vidWord.col.bLsb, vidWord.col.darkBit);

	// Output register
	// Shadow sampled here, same stage as the conversion
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			videoR <= 7'd0;
			videoG <= 7'd0;
			videoB <= 7'd0;
		end else if (vidBlank) begin
			// Blanking forces black whatever the palette says
			videoR <= 7'd0;
			videoG <= 7'd0;
			videoB <= 7'd0;
		end else begin
			videoR <= placeChan(chanR, shadow);
			videoG <= placeChan(chanG, shadow);
			videoB <= placeChan(chanB, shadow);
		end
	end

	// New pixel every clock, nothing stalls here

endmodule

/* logic/neoPalTop.sv */
module neoPalTop import neoPkg::*; #(
	parameter int palAddrW      = 12,
	parameter int palWaitStates = 1
) (
	input  logic                clk24M,
	input  logic                rstN,
	input  logic [23:1]         cpuAddr,
	input  logic                nAs,
	input  logic                nUds,
	input  logic                nLds,
	input  logic                cpuRw,
	input  logic [15:0]         cpuWrData,
	output logic [15:0]         cpuRdData,
	output logic                nDtack,
	input  logic [palAddrW-1:0] pixIdx,
	input  logic                blank,
	output logic [6:0]          videoR,
	output logic [6:0]          videoG,
	output logic [6:0]          videoB
);

	logic                palCs;
	logic [1:0]          palWe;
	logic                latchWe;
	logic                cpuRdSel;
	logic [palAddrW-1:0] cpuIdx;
	palWord              cpuPalData;
	logic                shadow;
	logic                palBank;
	palWord              vidWord;
	logic                vidBlank;

	// Bus decode and DTACK timing
	busDecode #(
		.palWaitStates(palWaitStates)
	) uBusDecode (
		.clk24M  (clk24M),
		.rstN    (rstN),
		.cpuAddr (cpuAddr),
		.nAs     (nAs),
		.nUds    (nUds),
		.nLds    (nLds),
		.cpuRw   (cpuRw),
		.palCs   (palCs),
		.palWe   (palWe),
		.latchWe (latchWe),
		.cpuRdSel(cpuRdSel),
		.nDtack  (nDtack)
	);

	// A4 is the data, A3..A1 the bit number
	sysLatch uSysLatch (
		.clk24M (clk24M),
		.rstN   (rstN),
		.latchWe(latchWe),
		.bitSel (cpuAddr[3:1]),
		.bitVal (cpuAddr[4]),
		.shadow (shadow),
		.palBank(palBank)
	);

	// Palette index only driven while selected
	assign cpuIdx = palCs ? cpuAddr[palAddrW:1] : '0;

	paletteRam #(
		.palAddrW(palAddrW)
	) uPaletteRam (
		.clk24M    (clk24M),
		.rstN      (rstN),
		.palBank   (palBank),
		.cpuIdx    (cpuIdx),
		.palWe     (palWe),
		.cpuWrData (cpuWrData),
		.cpuPalData(cpuPalData),
		.pixIdx    (pixIdx),
		.blank     (blank),
		.vidWord   (vidWord),
		.vidBlank  (vidBlank)
	);

	videoOut uVideoOut (
		.clk24M  (clk24M),
		.rstN    (rstN),
		.vidWord (vidWord),
		.vidBlank(vidBlank),
		.shadow  (shadow),
		.videoR  (videoR),
		.videoG  (videoG),
		.videoB  (videoB)
	);

	// Latch and unmapped reads float high
	assign cpuRdData = cpuRdSel ? cpuPalData.raw : openBusWord;

endmodule

/* verif/neoPalChk.sv */
module neoPalChk (
	input logic       clk24M,
	input logic       rstN,
	input logic       nAs,
	input logic       nDtack,
	input logic       blank,
	input logic [6:0] videoR,
	input logic [6:0] videoG,
	input logic [6:0] videoB,
	input logic       latchWe,
	input logic       shadow,
	input logic       palBank
);

	// Failure tally, the testbench folds it into its result
	int assertFails = 0;

	// nAs up for two samples means the cycle is over
	dtackRelease: assert property (@(posedge clk24M) disable iff (!rstN)
		(nAs && $past(nAs)) |-> nDtack)
		else begin
			$error("nDtack held low after nAs was released");
			assertFails++;
		end

	// Palette stage plus output stage
	blankBlack: assert property (@(posedge clk24M) disable iff (!rstN)
		blank |-> ##2 (videoR == 7'd0 && videoG == 7'd0 && videoB == 7'd0))
		else begin
			$error("RGB not black two cycles after blank");
			assertFails++;
		end

	// Latch bits only move on the edge that consumed latchWe
	latchQuiet: assert property (@(posedge clk24M) disable iff (!rstN)
		!$stable({shadow, palBank}) |-> $past(latchWe))
		else begin
			$error("latch output changed without latchWe");
			assertFails++;
		end

endmodule

bind neoPalTop neoPalChk chk0 (.*);

/* verif/neoPalMon.sv */
module neoPalMon #(
	parameter int palWaitStates = 1
) (
	input  logic        clk24M,
	input  logic        rstN,
	input  logic [23:1] cpuAddr,
	input  logic        nAs,
	input  logic        nUds,
	input  logic        nLds,
	input  logic        cpuRw,
	input  logic [15:0] cpuWrData,
	input  logic [15:0] cpuRdData,
	input  logic        nDtack,
	input  logic [11:0] pixIdx,
	input  logic        blank,
	input  logic [6:0]  videoR,
	input  logic [6:0]  videoG,
	input  logic [6:0]  videoB,
	input  logic [15:0] expWord,
	output int          errCount,
	output int          checkCount
);

	// Reference palette keyed by {bank, index}
	// Missing key means never written
	logic [15:0] palModel [int];
	logic [7:0]  latchModel;
	logic        prevDtack;
	logic [23:0] byteAddr;
	logic        inPal;
	logic        inLatch;
	logic [15:0] want;
	logic [15:0] p1Word;
	logic        p1Blank;
	logic        p1Valid;
	logic [20:0] p2Rgb;
	logic        p2Valid;
	int          waitSeen;
	int          wantWait;

	function automatic logic [15:0] peek(input logic bank, input logic [11:0] idx);
		int key;
		key = {bank, idx};
		return palModel.exists(key) ? palModel[key] : 16'h0000;
	endfunction

	// 6-bit level is nibble*4 + lsb*2 + not dark
	// Doubled unless shaded
	function automatic logic [6:0] level(input logic [3:0] field, input logic lsb,
		input logic dark, input logic shade);
		int v;
		v = field * 4 + lsb * 2 + (dark ? 0 : 1);
		if (!shade) begin
			v = v * 2;
		end
		return 7'(v);
	endfunction

	// Bit 15 dark, 14..12 R/G/B lsb, then R, G, B nibbles
	function automatic logic [20:0] colour(input logic [15:0] w, input logic blk,
		input logic shade);
		if (blk) begin
			return '0;
		end
		return {level(w[11:8], w[14], w[15], shade), level(w[7:4], w[13], w[15], shade),
			level(w[3:0], w[12], w[15], shade)};
	endfunction

	// Sampled on negedge where posedge-driven values have settled
	always @(negedge clk24M) begin
		if (!rstN) begin
			palModel.delete();
			latchModel = 8'h00;
			prevDtack  = 1'b1;
			p1Valid    = 1'b0;
			p2Valid    = 1'b0;
			waitSeen   = 0;
		end else begin
			// Falling nDtack marks the commit edge
			if (prevDtack && !nDtack) begin
				byteAddr = {cpuAddr, 1'b0};
				inPal    = byteAddr >= 24'h400000 && byteAddr <= 24'h7FFFFF;
				inLatch  = byteAddr >= 24'h3A0000 && byteAddr <= 24'h3BFFFF;
				// Palette needs its extra wait states on top
				wantWait = inPal ? 2 + palWaitStates : 2;
				checkCount++;
				if (waitSeen != wantWait) begin
					$display("Error at %0t: nDtack 0x%06h expected %0d cycles got %0d",
						$time, byteAddr, wantWait, waitSeen);
					errCount++;
				end
				if (cpuRw) begin
					want = inPal ? peek(latchModel[7], cpuAddr[12:1]) : 16'hFFFF;
					checkCount++;
					if (cpuRdData !== want) begin
						$display("Error at %0t: read 0x%06h expected %04h got %04h",
							$time, byteAddr, want, cpuRdData);
						errCount++;
					end
					if (want !== expWord) begin
						$display("Error at %0t: model word %04h differs from table %04h",
							$time, want, expWord);
						errCount++;
					end
				end else if (inPal) begin
					want = peek(latchModel[7], cpuAddr[12:1]);
					if (!nUds) begin
						want[15:8] = cpuWrData[15:8];
					end
					if (!nLds) begin
						want[7:0] = cpuWrData[7:0];
					end
					palModel[{latchModel[7], cpuAddr[12:1]}] = want;
				end else if (inLatch) begin
					latchModel[cpuAddr[3:1]] = cpuAddr[4];
				end
			end
			// Negedges with nAs low before nDtack falls
			if (nAs) begin
				waitSeen = 0;
			end else if (nDtack) begin
				waitSeen++;
			end
			prevDtack = nDtack;
			// Output of the pixel seen two negedges ago
			if (p2Valid) begin
				checkCount++;
				if ({videoR, videoG, videoB} !== p2Rgb) begin
					$display("Error at %0t: pixel expected %06h got %06h",
						$time, p2Rgb, {videoR, videoG, videoB});
					errCount++;
				end
			end
			// Shadow as the output stage will see it
			p2Valid = p1Valid;
			p2Rgb   = colour(p1Word, p1Blank, latchModel[0]);
			// Lookup uses the bank before the next edge
			p1Word  = peek(latchModel[7], pixIdx);
			p1Blank = blank;
			p1Valid = 1'b1;
		end
	end

endmodule

/* verif/neoPalTb.sv */
module neoPalTb;

	localparam int busTimeout = 50;
	localparam int waitStates = 1;

	localparam logic [1:0] kWrite  = 2'd0;
	localparam logic [1:0] kRead   = 2'd1;
	localparam logic [1:0] kPixels = 2'd2;

	// Strobes are {UDS, LDS} active high
	// Data is write word or expected read word
	// Pixel bursts use addr as the index mask and data as the pixel count
	typedef struct packed {
		logic [1:0]  kind;
		logic [23:0] addr;
		logic [1:0]  strb;
		logic [15:0] data;
	} stepT;

	localparam int numSteps = 19;
	localparam stepT steps [numSteps] = '{
		'{kWrite,  24'h400000, 2'b11, 16'h8F3C},
		'{kWrite,  24'h400002, 2'b11, 16'h7A51},
		'{kWrite,  24'h400004, 2'b10, 16'h12AA},
		'{kWrite,  24'h400004, 2'b01, 16'hCD56},
		'{kRead,   24'h400004, 2'b11, 16'h1256},
		'{kRead,   24'h400006, 2'b11, 16'h0000},
		'{kPixels, 24'h000007, 2'b00, 16'd24},
		'{kWrite,  24'h3A001E, 2'b11, 16'h0000},
		'{kWrite,  24'h400000, 2'b11, 16'h0123},
		'{kRead,   24'h400000, 2'b11, 16'h0123},
		'{kPixels, 24'h000003, 2'b00, 16'd16},
		'{kWrite,  24'h3A000E, 2'b11, 16'h0000},
		'{kRead,   24'h400000, 2'b11, 16'h8F3C},
		'{kWrite,  24'h3A0010, 2'b11, 16'h0000},
		'{kPixels, 24'h000007, 2'b00, 16'd20},
		'{kWrite,  24'h3A0000, 2'b11, 16'h0000},
		'{kRead,   24'h200000, 2'b11, 16'hFFFF},
		'{kRead,   24'h3A0010, 2'b11, 16'hFFFF},
		'{kPixels, 24'h00000F, 2'b00, 16'd32}
	};

	logic        clk24M;
	logic        rstN;
	logic [23:1] cpuAddr;
	logic        nAs;
	logic        nUds;
	logic        nLds;
	logic        cpuRw;
	logic [15:0] cpuWrData;
	logic [15:0] cpuRdData;
	logic        nDtack;
	logic [11:0] pixIdx;
	logic        blank;
	logic [6:0]  videoR;
	logic [6:0]  videoG;
	logic [6:0]  videoB;
	logic [15:0] expWord;
	int          errCount;
	int          checkCount;
	int          timeouts;
	logic [31:0] rngState;

	neoPalTop #(.palAddrW(12), .palWaitStates(waitStates)) dut0 (.*);

	neoPalMon #(.palWaitStates(waitStates)) mon0 (.*);

	initial begin
		clk24M = 1'b0;
		forever #2 clk24M = ~clk24M;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic waitDtack(input logic level, input logic [23:0] addr);
		int n;
		n = 0;
		do begin
			@(negedge clk24M);
			n++;
		end while (nDtack !== level && n < busTimeout);
		if (nDtack !== level) begin
			$display("Timeout: nDtack never went %s for address 0x%06h",
				level ? "high" : "low", addr);
			timeouts++;
		end
	endtask

	// One 68K cycle with strobes dropped together with nAs
	task automatic busCycle(input stepT s);
		@(posedge clk24M);
		cpuAddr   <= s.addr[23:1];
		cpuRw     <= (s.kind == kRead);
		nUds      <= ~s.strb[1];
		nLds      <= ~s.strb[0];
		cpuWrData <= s.data;
		expWord   <= s.data;
		nAs       <= 1'b0;
		waitDtack(1'b0, s.addr);
		@(posedge clk24M);
		nAs  <= 1'b1;
		nUds <= 1'b1;
		nLds <= 1'b1;
		waitDtack(1'b1, s.addr);
	endtask

	// Back to back pixels with about one in eight blanked
	task automatic pixelBurst(input logic [11:0] mask, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk24M);
			rngState = xorshift(rngState);
			pixIdx <= rngState[11:0] & mask;
			blank  <= (rngState[31:29] == 3'b000);
		end
		@(posedge clk24M);
		blank <= 1'b1;
	endtask

	initial begin : main
		int total;
		rstN      = 1'b0;
		cpuAddr   = '0;
		nAs       = 1'b1;
		nUds      = 1'b1;
		nLds      = 1'b1;
		cpuRw     = 1'b1;
		cpuWrData = 16'h0000;
		pixIdx    = 12'h000;
		blank     = 1'b1;
		expWord   = 16'hFFFF;
		timeouts  = 0;
		rngState  = 32'd55496;
		repeat (10) @(posedge clk24M);
		rstN <= 1'b1;
		repeat (2) @(posedge clk24M);
		foreach (steps[i]) begin
			if (steps[i].kind == kPixels) begin
				pixelBurst(steps[i].addr[11:0], int'(steps[i].data));
			end else begin
				busCycle(steps[i]);
			end
		end
		// Drain the video pipe
		// Counts are read on a posedge while the monitor sits idle
		repeat (4) @(posedge clk24M);
		total = errCount + timeouts + dut0.chk0.assertFails;
		$display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
			checkCount, errCount, timeouts, dut0.chk0.assertFails);
		if (total == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
logic/neoPkg.sv
logic/busDecode.sv
logic/sysLatch.sv
logic/paletteRam.sv
logic/videoOut.sv
logic/neoPalTop.sv
verif/neoPalChk.sv
verif/neoPalMon.sv
verif/neoPalTb.sv

/* Bender.yml */
package:
  name: neo_pal

sources:
  - files:
      - logic/neoPkg.sv
      - logic/busDecode.sv
      - logic/sysLatch.sv
      - logic/paletteRam.sv
      - logic/videoOut.sv
      - logic/neoPalTop.sv
  - target: test
    files:
      - verif/neoPalChk.sv
      - verif/neoPalMon.sv
      - verif/neoPalTb.sv
